/* rtl/msx_upload_defs.svh */
`ifndef MSX_UPLOAD_DEFS_SVH
`define MSX_UPLOAD_DEFS_SVH

`define DDR_ADDR_W      28
`define RAM_ADDR_W      27
`define IMG_SIZE_W      27

// Size field of a record counts 16 KB units
`define FILL_UNIT_SHIFT 14
`define REC_BYTES       16

`define CONF_INDEX      1

`define SIG_0           8'h4D   // "M"
`define SIG_1           8'h53   // "S"
`define SIG_2           8'h58   // "X"

`endif

/* rtl/msx_upload_pkg.sv */
`include "msx_upload_defs.svh"

package msx_upload_pkg;

   typedef logic [`DDR_ADDR_W-1:0] ddr_addr_t;
   typedef logic [`RAM_ADDR_W-1:0] ram_addr_t;
   typedef logic [`IMG_SIZE_W-1:0] img_size_t;
   typedef logic [24:0]            fill_size_t;   // Region length in bytes
   typedef logic [5:0]             block_idx_t;   // Slot, subslot, block
   typedef logic [3:0]             ram_ref_t;

   // Four 2-bit fields with block 0 in bits 1:0
   typedef logic [7:0] mode_t;
   typedef logic [7:0] param_t;

   typedef logic [7:0] mapper_t;
   typedef logic [7:0] device_t;

   localparam mapper_t MAPPER_UNUSED = 8'hFF;
   localparam device_t DEVICE_NONE   = 8'h00;

   typedef enum logic [2:0] {
      PAT_COPY    = 3'd0,
      PAT_FF      = 3'd1,
      PAT_00      = 3'd2,
      PAT_CHECK_A = 3'd3,
      PAT_CHECK_B = 3'd4,
      PAT_HALF    = 3'd5
   } pattern_t;

   typedef enum logic [7:0] {ROM_NONE = 8'd0, ROM_ROM = 8'd1, ROM_RAM = 8'd2} data_id_t;

   typedef enum logic [3:0] {CONF_SLOT_INTERNAL = 4'd4} conf_typ_t;

   typedef enum logic [2:0] {S_IDLE, S_CLEAN, S_READ, S_CHECK, S_FILL, S_STORE} seq_state_t;

endpackage

/* rtl/download_tracker.sv */
`timescale 1ns/1ps
`include "msx_upload_defs.svh"

module download_tracker (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      ioctl_download,
   input  logic [15:0]               ioctl_index,
   input  msx_upload_pkg::img_size_t ioctl_addr,
   input  logic                      reload,
   output logic                      load,
   output msx_upload_pkg::img_size_t img_size
);
   logic dl_last;
   logic conf_end;

   // Falling edge of the config image download
   assign conf_end = dl_last & ~ioctl_download & (ioctl_index[5:0] == 6'(`CONF_INDEX));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dl_last  <= 1'b0;
         load     <= 1'b0;
         img_size <= '0;
      end else begin
         dl_last <= ioctl_download;
         load    <= conf_end | reload;
         if (conf_end)
            img_size <= ioctl_addr;   // Last address is the image size
      end
   end

endmodule

/* rtl/ddr_byte_reader.sv */
`timescale 1ns/1ps

module ddr_byte_reader (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      addr_load,
   input  msx_upload_pkg::ddr_addr_t addr_value,
   input  logic                      byte_req,
   output logic                      byte_valid,
   output logic [7:0]                byte_data,
   output msx_upload_pkg::ddr_addr_t cur_addr,
   output msx_upload_pkg::ddr_addr_t ddr3_addr,
   output logic                      ddr3_rd,
   input  logic [7:0]                ddr3_dout,
   input  logic                      ddr3_ready
);
   logic rd_done;

   assign rd_done  = ddr3_rd & ddr3_ready;
   assign cur_addr = ddr3_addr;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ddr3_rd    <= 1'b0;
         ddr3_addr  <= '0;
         byte_valid <= 1'b0;
      end else begin
         byte_valid <= rd_done;
         if (addr_load) begin
            ddr3_addr <= addr_value;   // Restart drops any read in flight
            ddr3_rd   <= 1'b0;
         end else if (rd_done) begin
            ddr3_rd   <= 1'b0;
            ddr3_addr <= ddr3_addr + 1'b1;
         end else if (byte_req) begin
            ddr3_rd <= 1'b1;           // Held until ddr3_ready
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_done)
         byte_data <= ddr3_dout;
   end

endmodule

/* rtl/record_sequencer.sv */
`timescale 1ns/1ps
`include "msx_upload_defs.svh"

module record_sequencer (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       load,
   input  msx_upload_pkg::img_size_t  img_size,
   output logic                       addr_load,
   output msx_upload_pkg::ddr_addr_t  addr_value,
   output logic                       byte_req,
   input  logic                       byte_valid,
   input  logic [7:0]                 byte_data,
   input  msx_upload_pkg::ddr_addr_t  cur_addr,
   output logic                       fill_start,
   output msx_upload_pkg::ram_addr_t  fill_base,
   output msx_upload_pkg::fill_size_t fill_size,
   output msx_upload_pkg::pattern_t   fill_pattern,
   input  logic                       fill_done,
   output logic                       clear_block,
   output msx_upload_pkg::block_idx_t block_idx,
   output logic                       store_slot,
   output logic [3:0]                 slot_sub,
   output msx_upload_pkg::mode_t      mode,
   output msx_upload_pkg::param_t     param,
   output msx_upload_pkg::mapper_t    mapper,
   output msx_upload_pkg::device_t    device,
   output msx_upload_pkg::ram_ref_t   ref_ram,
   output logic                       lookup_wr,
   output msx_upload_pkg::ram_addr_t  lookup_base,
   output logic [15:0]                lookup_units,
   output logic                       lookup_ro,
   output logic                       reset_rq
);
   msx_upload_pkg::seq_state_t state;
   msx_upload_pkg::block_idx_t blk;
   msx_upload_pkg::ram_ref_t   ref_cnt;
   msx_upload_pkg::ram_addr_t  ram_base;
   msx_upload_pkg::data_id_t   data_id;
   logic [7:0]                 conf [`REC_BYTES];
   logic [3:0]                 cnt;
   logic                       pending;
   logic [10:0]                units;
   logic                       sig_ok;
   logic                       has_data;

   assign sig_ok   = {conf[0], conf[1], conf[2]} == {`SIG_0, `SIG_1, `SIG_2};
   assign units    = {conf[5][2:0], conf[6]};
   assign has_data = units != 11'd0;
   assign data_id  = msx_upload_pkg::data_id_t'(conf[4]);

   assign reset_rq    = state != msx_upload_pkg::S_IDLE;
   assign clear_block = state == msx_upload_pkg::S_CLEAN;
   assign store_slot  = state == msx_upload_pkg::S_STORE;
   assign block_idx   = blk;

   assign slot_sub = conf[3][3:0];
   assign device   = conf[4];
   assign mapper   = conf[8];
   assign mode     = conf[9];
   assign param    = conf[10];
   assign ref_ram  = has_data ? ref_cnt : '0;   // Empty region points at entry 0

   assign fill_base    = ram_base;
   assign fill_size    = msx_upload_pkg::fill_size_t'(units) << `FILL_UNIT_SHIFT;
   assign fill_pattern = (data_id == msx_upload_pkg::ROM_RAM) ?
                         msx_upload_pkg::pattern_t'(conf[11][2:0]) : msx_upload_pkg::PAT_COPY;
   assign lookup_base  = ram_base;
   assign lookup_units = 16'(units);
   assign lookup_ro    = data_id != msx_upload_pkg::ROM_RAM;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= msx_upload_pkg::S_IDLE;
         blk        <= '0;
         cnt        <= '0;
         pending    <= 1'b0;
         ref_cnt    <= '0;
         ram_base   <= '0;
         addr_load  <= 1'b0;
         addr_value <= '0;
         byte_req   <= 1'b0;
         fill_start <= 1'b0;
         lookup_wr  <= 1'b0;
      end else begin
         addr_load  <= 1'b0;
         byte_req   <= 1'b0;
         fill_start <= 1'b0;
         lookup_wr  <= 1'b0;
         if (load) begin
            state      <= msx_upload_pkg::S_CLEAN;
            blk        <= '0;
            cnt        <= '0;
            pending    <= 1'b0;
            ref_cnt    <= '0;
            ram_base   <= '0;
            addr_load  <= 1'b1;   // Chain starts at DDR address 0
            addr_value <= '0;
         end else begin
            case (state)
               msx_upload_pkg::S_CLEAN: begin
                  blk <= blk + 1'b1;
                  if (blk == 6'd63)
                     state <= msx_upload_pkg::S_READ;
               end
               msx_upload_pkg::S_READ: begin
                  if (!pending) begin
                     if (cnt == 4'd0 && cur_addr >= msx_upload_pkg::ddr_addr_t'(img_size)) begin
                        state <= msx_upload_pkg::S_IDLE;   // End of image
                     end else begin
                        byte_req <= 1'b1;
                        pending  <= 1'b1;
                     end
                  end else if (byte_valid) begin
                     conf[cnt] <= byte_data;
                     pending   <= 1'b0;
                     cnt       <= cnt + 1'b1;
                     if (cnt == 4'(`REC_BYTES - 1))
                        state <= msx_upload_pkg::S_CHECK;
                  end
               end
               msx_upload_pkg::S_CHECK: begin
                  if (!sig_ok || conf[3][7:4] != msx_upload_pkg::CONF_SLOT_INTERNAL) begin
                     state <= msx_upload_pkg::S_IDLE;
                  end else if (!has_data) begin
                     state <= msx_upload_pkg::S_STORE;
                  end else begin
                     fill_start <= 1'b1;
                     lookup_wr  <= 1'b1;
                     state      <= msx_upload_pkg::S_FILL;
                  end
               end
               msx_upload_pkg::S_FILL: begin
                  if (fill_done) begin
                     ram_base <= ram_base + msx_upload_pkg::ram_addr_t'(fill_size);
                     state    <= msx_upload_pkg::S_STORE;
                  end
               end
               msx_upload_pkg::S_STORE: begin
                  ref_cnt <= ref_cnt + 4'(has_data);
                  state   <= msx_upload_pkg::S_READ;   // Next record follows the data
               end
               default: ;
            endcase
         end
      end
   end

endmodule

/* rtl/ram_filler.sv */
`timescale 1ns/1ps

module ram_filler (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       fill_start,
   input  msx_upload_pkg::ram_addr_t  fill_base,
   input  msx_upload_pkg::fill_size_t fill_size,
   input  msx_upload_pkg::pattern_t   fill_pattern,
   output logic                       fill_done,
   output logic                       byte_req,
   input  logic                       byte_valid,
   input  logic [7:0]                 byte_data,
   output msx_upload_pkg::ram_addr_t  ram_addr,
   output logic [7:0]                 ram_din,
   output logic                       ram_ce,
   input  logic                       sdram_ready
);
   msx_upload_pkg::fill_size_t remaining;
   msx_upload_pkg::ram_addr_t  base;
   msx_upload_pkg::pattern_t   pattern;
   logic                       active;
   logic                       waiting;
   logic                       have_byte;
   logic [7:0]                 copy_byte;
   logic [7:0]                 gen;
   logic [8:0]                 o;
   logic                       copy;

   assign copy = pattern == msx_upload_pkg::PAT_COPY;

   always_comb begin
      o = 9'(ram_addr - base);   // Offset inside the region
      case (pattern)
         msx_upload_pkg::PAT_00:      gen = 8'h00;
         msx_upload_pkg::PAT_CHECK_A: gen = (o[8] == o[1]) ? 8'hFF : 8'h00;
         msx_upload_pkg::PAT_CHECK_B: gen = (o[8] != o[0]) ? 8'hFF : 8'h00;
         msx_upload_pkg::PAT_HALF:    gen = o[7] ? 8'hFF : 8'h00;
         default:                     gen = 8'hFF;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         active    <= 1'b0;
         waiting   <= 1'b0;
         have_byte <= 1'b0;
         byte_req  <= 1'b0;
         ram_ce    <= 1'b0;
         fill_done <= 1'b0;
         ram_addr  <= '0;
      end else begin
         byte_req  <= 1'b0;
         ram_ce    <= 1'b0;
         fill_done <= 1'b0;
         if (ram_ce)
            ram_addr <= ram_addr + 1'b1;
         if (fill_start) begin
            active    <= 1'b1;
            waiting   <= 1'b0;
            have_byte <= 1'b0;
            ram_addr  <= fill_base;
         end else if (active) begin
            if (copy && !have_byte) begin
               if (!waiting) begin
                  byte_req <= 1'b1;
                  waiting  <= 1'b1;
               end else if (byte_valid) begin
                  waiting   <= 1'b0;
                  have_byte <= 1'b1;
               end
            end else if (sdram_ready && !ram_ce) begin
               ram_ce    <= 1'b1;
               have_byte <= 1'b0;
               if (remaining == 25'd1) begin
                  active    <= 1'b0;
                  fill_done <= 1'b1;
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fill_start) begin
         base      <= fill_base;
         remaining <= fill_size;
         pattern   <= fill_pattern;
      end else if (active && (!copy || have_byte) && sdram_ready && !ram_ce) begin
         remaining <= remaining - 1'b1;
         ram_din   <= copy ? copy_byte : gen;
      end
      if (byte_valid && waiting)
         copy_byte <= byte_data;
   end

endmodule

/* rtl/memory_map_table.sv */
`timescale 1ns/1ps

module memory_map_table (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       clear_block,
   input  msx_upload_pkg::block_idx_t block_idx,
   input  logic                       store_slot,
   input  logic [3:0]                 slot_sub,
   input  msx_upload_pkg::mode_t      mode,
   input  msx_upload_pkg::param_t     param,
   input  msx_upload_pkg::mapper_t    mapper,
   input  msx_upload_pkg::device_t    device,
   input  msx_upload_pkg::ram_ref_t   ref_ram,
   input  logic                       lookup_wr,
   input  msx_upload_pkg::ram_ref_t   lookup_ref,
   input  msx_upload_pkg::ram_addr_t  lookup_base,
   input  logic [15:0]                lookup_units,
   input  logic                       lookup_ro,
   input  msx_upload_pkg::block_idx_t layout_idx,
   output msx_upload_pkg::mapper_t    layout_mapper,
   output msx_upload_pkg::device_t    layout_device,
   output msx_upload_pkg::ram_ref_t   layout_ref,
   output logic [1:0]                 layout_offset,
   input  msx_upload_pkg::ram_ref_t   ram_idx,
   output msx_upload_pkg::ram_addr_t  ram_base,
   output logic [15:0]                ram_units,
   output logic                       ram_ro
);
   msx_upload_pkg::mapper_t   lay_mapper [64];
   msx_upload_pkg::device_t   lay_device [64];
   msx_upload_pkg::ram_ref_t  lay_ref    [64];
   logic [1:0]                lay_offset [64];
   msx_upload_pkg::ram_addr_t lk_base    [16];
   logic [15:0]               lk_units   [16];
   logic                      lk_ro      [16];

   assign layout_mapper = lay_mapper[layout_idx];
   assign layout_device = lay_device[layout_idx];
   assign layout_ref    = lay_ref[layout_idx];
   assign layout_offset = lay_offset[layout_idx];
   assign ram_base      = lk_base[ram_idx];
   assign ram_units     = lk_units[ram_idx];
   assign ram_ro        = lk_ro[ram_idx];

   always_ff @(posedge clk) begin
      msx_upload_pkg::block_idx_t dst;
      msx_upload_pkg::block_idx_t src;
      if (clear_block) begin
         lay_mapper[block_idx] <= msx_upload_pkg::MAPPER_UNUSED;
         lay_device[block_idx] <= msx_upload_pkg::DEVICE_NONE;
         lay_ref[block_idx]    <= '0;
         lay_offset[block_idx] <= 2'd0;
      end
      if (store_slot) begin
         for (int i = 0; i < 4; i++) begin
            dst = {slot_sub, 2'(i)};
            src = {slot_sub, param[i*2 +: 2]};   // Mirror source read before the store
            case (mode[i*2 +: 2])
               2'd1: begin
                  lay_mapper[dst] <= lay_mapper[src];
                  lay_device[dst] <= lay_device[src];
                  lay_ref[dst]    <= lay_ref[src];
                  lay_offset[dst] <= lay_offset[src];
               end
               2'd2, 2'd3: begin
                  lay_mapper[dst] <= (mode[i*2 +: 2] == 2'd2) ? mapper :
                                     msx_upload_pkg::MAPPER_UNUSED;
                  lay_device[dst] <= device;
                  lay_ref[dst]    <= ref_ram;
                  lay_offset[dst] <= param[i*2 +: 2];
               end
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < 16; i++)
            lk_units[i] <= 16'd0;   // Zero units marks an unused entry
      end else if (lookup_wr) begin
         lk_units[lookup_ref] <= lookup_units;
      end
      if (lookup_wr) begin
         lk_base[lookup_ref] <= lookup_base;
         lk_ro[lookup_ref]   <= lookup_ro;
      end
   end

endmodule

/* rtl/memory_upload.sv */
`timescale 1ns/1ps

module memory_upload (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       ioctl_download,
   input  logic [15:0]                ioctl_index,
   input  msx_upload_pkg::img_size_t  ioctl_addr,
   input  logic                       reload,
   output logic                       reset_rq,
   output msx_upload_pkg::ddr_addr_t  ddr3_addr,
   output logic                       ddr3_rd,
   input  logic [7:0]                 ddr3_dout,
   input  logic                       ddr3_ready,
   output msx_upload_pkg::ram_addr_t  ram_addr,
   output logic [7:0]                 ram_din,
   output logic                       ram_ce,
   input  logic                       sdram_ready,
   input  msx_upload_pkg::block_idx_t layout_idx,
   output msx_upload_pkg::mapper_t    layout_mapper,
   output msx_upload_pkg::device_t    layout_device,
   output msx_upload_pkg::ram_ref_t   layout_ref,
   output logic [1:0]                 layout_offset,
   input  msx_upload_pkg::ram_ref_t   ram_idx,
   output msx_upload_pkg::ram_addr_t  ram_base,
   output logic [15:0]                ram_units,
   output logic                       ram_ro
);
   logic                       load, addr_load, seq_byte_req, fill_byte_req, byte_valid;
   logic                       fill_start, fill_done, clear_block, store_slot;
   logic                       lookup_wr, lookup_ro;
   logic [7:0]                 byte_data;
   logic [3:0]                 slot_sub;
   logic [15:0]                lookup_units;
   msx_upload_pkg::img_size_t  img_size;
   msx_upload_pkg::ddr_addr_t  addr_value, cur_addr;
   msx_upload_pkg::ram_addr_t  fill_base, lookup_base;
   msx_upload_pkg::fill_size_t fill_size;
   msx_upload_pkg::pattern_t   fill_pattern;
   msx_upload_pkg::block_idx_t block_idx;
   msx_upload_pkg::mode_t      mode;
   msx_upload_pkg::param_t     param;
   msx_upload_pkg::mapper_t    mapper;
   msx_upload_pkg::device_t    device;
   msx_upload_pkg::ram_ref_t   ref_ram;

   download_tracker u_tracker (
      .clk, .rst_n, .ioctl_download, .ioctl_index, .ioctl_addr, .reload, .load, .img_size
   );

   // Sequencer and filler never request at the same time
   ddr_byte_reader u_reader (
      .clk, .rst_n, .addr_load, .addr_value, .byte_req(seq_byte_req | fill_byte_req),
      .byte_valid, .byte_data, .cur_addr, .ddr3_addr, .ddr3_rd, .ddr3_dout, .ddr3_ready
   );

   record_sequencer u_seq (
      .clk, .rst_n, .load, .img_size, .addr_load, .addr_value, .byte_req(seq_byte_req),
      .byte_valid, .byte_data, .cur_addr, .fill_start, .fill_base, .fill_size,
      .fill_pattern, .fill_done, .clear_block, .block_idx, .store_slot, .slot_sub,
      .mode, .param, .mapper, .device, .ref_ram, .lookup_wr, .lookup_base,
      .lookup_units, .lookup_ro, .reset_rq
   );

   ram_filler u_filler (
      .clk, .rst_n, .fill_start, .fill_base, .fill_size, .fill_pattern, .fill_done,
      .byte_req(fill_byte_req), .byte_valid, .byte_data, .ram_addr, .ram_din, .ram_ce,
      .sdram_ready
   );

   memory_map_table u_table (
      .clk, .rst_n, .clear_block, .block_idx, .store_slot, .slot_sub, .mode, .param,
      .mapper, .device, .ref_ram, .lookup_wr, .lookup_ref(ref_ram), .lookup_base,
      .lookup_units, .lookup_ro, .layout_idx, .layout_mapper, .layout_device,
      .layout_ref, .layout_offset, .ram_idx, .ram_base, .ram_units, .ram_ro
   );

endmodule

/* verif/upload_tests.svh */
// Internal slot record with all unused bytes zero
task automatic put_record(input int at, input logic [3:0] slot_sub, input logic [7:0] id_dev,
                          input logic [10:0] units, input logic [7:0] map_code,
                          input logic [7:0] mode_f, input logic [7:0] param_f,
                          input logic [7:0] pattern_f);
   for (int i = 0; i < `REC_BYTES; i++)
      ddr_mem[at + i] = 8'h00;
   ddr_mem[at + 0]  = `SIG_0;
   ddr_mem[at + 1]  = `SIG_1;
   ddr_mem[at + 2]  = `SIG_2;
   ddr_mem[at + 3]  = {4'h4, slot_sub};
   ddr_mem[at + 4]  = id_dev;      // data_id doubles as device
   ddr_mem[at + 5]  = {5'd0, units[10:8]};
   ddr_mem[at + 6]  = units[7:0];
   ddr_mem[at + 8]  = map_code;
   ddr_mem[at + 9]  = mode_f;
   ddr_mem[at + 10] = param_f;
   ddr_mem[at + 11] = pattern_f;
endtask

task automatic fill_rom_data(input int at);
   for (int i = 0; i < 16384; i++)
      ddr_mem[at + i] = 8'(next_rand());
endtask

task automatic download_image(input logic [15:0] index, input int size);
   @(posedge clk);
   ioctl_index    <= index;
   ioctl_addr     <= msx_upload_pkg::img_size_t'(size);
   ioctl_download <= 1'b1;
   repeat (3) @(posedge clk);
   ioctl_download <= 1'b0;
endtask

task automatic wait_walk();
   int n;
   n = 0;
   while (!reset_rq && n < 4) begin
      @(negedge clk);
      n++;
   end
   if (!reset_rq)
      stop_with_failure("reset_rq did not rise after the load");
   while (reset_rq)
      @(negedge clk);
endtask

task automatic check_entry(input int idx, input msx_upload_pkg::mapper_t map_e,
                           input msx_upload_pkg::device_t dev_e,
                           input msx_upload_pkg::ram_ref_t ref_e, input logic [1:0] off_e);
   @(posedge clk);
   layout_idx <= msx_upload_pkg::block_idx_t'(idx);
   @(negedge clk);
   check_mapper($sformatf("layout %0d mapper", idx), map_e, layout_mapper);
   check_device($sformatf("layout %0d device", idx), dev_e, layout_device);
   check_ref($sformatf("layout %0d ref", idx), ref_e, layout_ref);
   check_offset($sformatf("layout %0d offset", idx), off_e, layout_offset);
endtask

task automatic check_lookup(input int r, input int base_e, input logic ro_e);
   @(posedge clk);
   ram_idx <= msx_upload_pkg::ram_ref_t'(r);
   @(negedge clk);
   check_ram_addr($sformatf("lookup %0d base", r), msx_upload_pkg::ram_addr_t'(base_e), ram_base);
   check_units($sformatf("lookup %0d units", r), 16'd1, ram_units);
   check_bit($sformatf("lookup %0d ro", r), ro_e, ram_ro);
endtask

// Checkerboard A is FF where offset bit 8 equals bit 1
function automatic logic [7:0] checker_a_byte(input int offset);
   logic [8:0] o;
   o = 9'(offset);
   return (o[8] == o[1]) ? 8'hFF : 8'h00;
endfunction

task automatic check_final_image();
   for (int i = 0; i < 16384; i++) begin
      check_byte($sformatf("ROM byte %0d", i), ddr_mem[16 + i], ram_mem[i]);
      check_byte($sformatf("RAM byte %0d", 16384 + i), checker_a_byte(i), ram_mem[16384 + i]);
   end
   check_ram_addr("ram_addr after fill", 27'd32768, ram_addr);
   check_lookup(0, 0, 1'b1);
   check_lookup(1, 16384, 1'b0);
   check_entry(16, 8'h09, 8'h02, 4'd1, 2'd1);
   check_entry(17, 8'h07, 8'h01, 4'd0, 2'd0);   // Block 0 as record 0 left it
   check_entry(18, 8'h07, 8'h01, 4'd0, 2'd2);
   check_entry(19, 8'h07, 8'h01, 4'd0, 2'd3);
endtask

task automatic idle_after_reset();
   test_name = "idle_after_reset";
   @(negedge clk);
   check_bit("reset_rq", 1'b0, reset_rq);
   check_bit("ddr3_rd", 1'b0, ddr3_rd);
   check_bit("ram_ce", 1'b0, ram_ce);
   download_image(16'd2, 16);
   repeat (6) begin
      @(negedge clk);
      check_bit("reset_rq after index 2", 1'b0, reset_rq);
   end
endtask

task automatic bad_signature_clears();
   test_name = "bad_signature_clears";
   put_record(0, 4'h0, 8'h22, 11'd0, 8'h11, 8'hAA, 8'h1B, 8'h00);
   download_image(16'd1, 16);
   wait_walk();
   check_entry(0, 8'h11, 8'h22, 4'd0, 2'd3);   // Seeded by an empty region
   ddr_mem[0] = 8'h00;
   download_image(16'd1, 16);
   wait_walk();
   for (int i = 0; i < 64; i++)
      check_entry(i, msx_upload_pkg::MAPPER_UNUSED, msx_upload_pkg::DEVICE_NONE, 4'd0, 2'd0);
   if (ram_writes != 0)
      stop_with_failure("ram_ce was issued by a walk that has no RAM region");
   check_ram_addr("ram_addr", '0, ram_addr);
endtask

task automatic rom_record_copies();
   test_name = "rom_record_copies";
   put_record(0, 4'h4, 8'h01, 11'd1, 8'h07, 8'hAA, 8'hE4, 8'h00);
   fill_rom_data(16);
   download_image(16'd1, 16400);
   wait_walk();
   for (int i = 0; i < 16384; i++)
      check_byte($sformatf("ROM byte %0d", i), ddr_mem[16 + i], ram_mem[i]);
   check_ram_addr("ram_addr after fill", 27'd16384, ram_addr);
   check_lookup(0, 0, 1'b1);
   for (int b = 0; b < 4; b++)
      check_entry(16 + b, 8'h07, 8'h01, 4'd0, 2'(b));
endtask

task automatic pattern_record_mirrors();
   test_name = "pattern_record_mirrors";
   put_record(16400, 4'h4, 8'h02, 11'd1, 8'h09, 8'h06, 8'h01, 8'h03);
   download_image(16'd1, 16416);
   wait_walk();
   check_final_image();
endtask

task automatic reload_with_stalls();
   int writes_before;
   test_name = "reload_with_stalls";
   for (int i = 0; i < 32768; i++)
      ram_mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'hA5;
   writes_before = ram_writes;
   @(posedge clk);
   stall_en <= 1'b1;
   reload   <= 1'b1;
   @(posedge clk);
   reload <= 1'b0;
   wait_walk();
   if (ram_writes - writes_before != 32768)
      stop_with_failure("reload did not rewrite both RAM regions exactly once");
   check_final_image();
endtask

/* verif/tb_memory_upload.sv */
`timescale 1ns/1ps
`include "msx_upload_defs.svh"

module tb_memory_upload;
   // Bytes read by the five walks
   localparam int TEST_BYTES     = 16 + 16 + 16400 + 16416 + 16416;
   localparam int TIMEOUT_CYCLES = 4 * TEST_BYTES * 8 + 2000;

   logic                       clk;
   logic                       rst_n;
   logic                       ioctl_download;
   logic [15:0]                ioctl_index;
   msx_upload_pkg::img_size_t  ioctl_addr;
   logic                       reload;
   logic                       reset_rq;
   msx_upload_pkg::ddr_addr_t  ddr3_addr;
   logic                       ddr3_rd;
   logic [7:0]                 ddr3_dout;
   logic                       ddr3_ready;
   msx_upload_pkg::ram_addr_t  ram_addr;
   logic [7:0]                 ram_din;
   logic                       ram_ce;
   logic                       sdram_ready;
   msx_upload_pkg::block_idx_t layout_idx;
   msx_upload_pkg::mapper_t    layout_mapper;
   msx_upload_pkg::device_t    layout_device;
   msx_upload_pkg::ram_ref_t   layout_ref;
   logic [1:0]                 layout_offset;
   msx_upload_pkg::ram_ref_t   ram_idx;
   msx_upload_pkg::ram_addr_t  ram_base;
   logic [15:0]                ram_units;
   logic                       ram_ro;

   logic [7:0]  ddr_mem [32768];
   logic [7:0]  ram_mem [32768];
   int          ram_writes = 0;
   int          cycles = 0;
   int unsigned lcg_state = 15937;
   logic [1:0]  ddr_wait;
   logic        stall_en;
   string       test_name = "";

   memory_upload u_dut (.*);

   function automatic logic [15:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return 16'(lcg_state >> 15);
   endfunction

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // DDR answers a held read after 1 to 4 cycles
   always @(posedge clk) begin
      if (ddr3_ready) begin
         ddr3_ready <= 1'b0;
      end else if (ddr3_rd) begin
         if (ddr_wait == 2'd0) begin
            ddr3_ready <= 1'b1;
            ddr3_dout  <= ddr_mem[ddr3_addr[14:0]];
            ddr_wait   <= stall_en ? 2'(next_rand()) : 2'd0;
         end else begin
            ddr_wait <= ddr_wait - 2'd1;
         end
      end
   end

   always @(posedge clk) begin
      sdram_ready <= !stall_en || (next_rand() > 16'h5000);
      if (ram_ce) begin
         if (ram_addr[26:15] != '0)
            stop_with_failure("ram_ce was issued outside the modelled RAM");
         ram_mem[ram_addr[14:0]] <= ram_din;
         ram_writes              <= ram_writes + 1;
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
         stop_with_failure("Timeout: the DUT did not finish its walks in time");
   end

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string what, input string exp_s, input string act_s);
      stop_with_failure($sformatf("[ERROR] %s: %s expected %s, actual %s",
                                  test_name, what, exp_s, act_s));
   endtask

   task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp) report_mismatch(what, $sformatf("%02h", exp), $sformatf("%02h", act));
   endtask

   task automatic check_mapper(input string what, input msx_upload_pkg::mapper_t exp,
                               input msx_upload_pkg::mapper_t act);
      if (act !== exp) report_mismatch(what, $sformatf("%02h", exp), $sformatf("%02h", act));
   endtask

   task automatic check_device(input string what, input msx_upload_pkg::device_t exp,
                               input msx_upload_pkg::device_t act);
      if (act !== exp) report_mismatch(what, $sformatf("%02h", exp), $sformatf("%02h", act));
   endtask

   task automatic check_ram_addr(input string what, input msx_upload_pkg::ram_addr_t exp,
                                 input msx_upload_pkg::ram_addr_t act);
      if (act !== exp) report_mismatch(what, $sformatf("%0h", exp), $sformatf("%0h", act));
   endtask

   task automatic check_ref(input string what, input msx_upload_pkg::ram_ref_t exp,
                            input msx_upload_pkg::ram_ref_t act);
      if (act !== exp) report_mismatch(what, $sformatf("%0d", exp), $sformatf("%0d", act));
   endtask

   task automatic check_units(input string what, input logic [15:0] exp, input logic [15:0] act);
      if (act !== exp) report_mismatch(what, $sformatf("%0d", exp), $sformatf("%0d", act));
   endtask

   task automatic check_offset(input string what, input logic [1:0] exp, input logic [1:0] act);
      if (act !== exp) report_mismatch(what, $sformatf("%0d", exp), $sformatf("%0d", act));
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (act !== exp) report_mismatch(what, $sformatf("%b", exp), $sformatf("%b", act));
   endtask

   `include "upload_tests.svh"

   initial begin
      rst_n          <= 1'b0;
      ioctl_download <= 1'b0;
      ioctl_index    <= '0;
      ioctl_addr     <= '0;
      reload         <= 1'b0;
      ddr3_dout      <= 8'h00;
      ddr3_ready     <= 1'b0;
      sdram_ready    <= 1'b1;
      layout_idx     <= '0;
      ram_idx        <= '0;
      ddr_wait       <= 2'd0;
      stall_en       <= 1'b0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      idle_after_reset();
      bad_signature_clears();
      rom_record_copies();
      pattern_record_mirrors();
      reload_with_stalls();
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

/* sim.f */
+incdir+rtl
+incdir+verif
rtl/msx_upload_pkg.sv
rtl/download_tracker.sv
rtl/ddr_byte_reader.sv
rtl/record_sequencer.sv
rtl/ram_filler.sv
rtl/memory_map_table.sv
rtl/memory_upload.sv
verif/tb_memory_upload.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_memory_upload -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi
